/* filelist.f */
rtl/mem_pkg.sv
rtl/replica_store.sv
rtl/port_select.sv
rtl/mem_4r1rw_top.sv
tb/mem_4r1rw_asserts.sv
tb/mem_4r1rw_tb.sv

/* Makefile */
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -j 0
TOP       ?= mem_4r1rw_tb
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "^PASS: all tests" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* tb/mem_4r1rw_tb.sv */
// Multiport memory testbench
`default_nettype none

module mem_4r1rw_tb;

  localparam int WIDTH    = 16;
  localparam int NUMADDR  = 64;
  localparam int BITADDR  = $clog2(NUMADDR);
  localparam int PADR_W   = 1 + mem_pkg::REP_BITS + BITADDR;
  localparam int HALF     = NUMADDR / 2;
  localparam int NPORT    = mem_pkg::NUM_RD + 1;  // Queue 4 is the rw port.
  localparam int TEST_CYC = 200;
  localparam int WDOG_CYC = 4 + NUMADDR + 1 + TEST_CYC;

  typedef logic [WIDTH-1:0]   word_t;
  typedef logic [BITADDR-1:0] addr_t;
  typedef logic [PADR_W-1:0]  padr_t;
  typedef logic [mem_pkg::NUM_RD-1:0][BITADDR-1:0] addr_vec_t;

  logic                                       clk;
  logic                                       rst_n;
  logic                                       ena_rdacc;
  logic                                       ready;
  logic                                       rw_read;
  logic                                       rw_write;
  addr_t                                      rw_addr;
  word_t                                      rw_din;
  word_t                                      rw_dout;
  logic                                       rw_vld;
  padr_t                                      rw_padr;
  logic [mem_pkg::NUM_RD-1:0]                 read;
  addr_vec_t                                  rd_adr;
  logic [mem_pkg::NUM_RD-1:0][WIDTH-1:0]      rd_dout;
  logic [mem_pkg::NUM_RD-1:0]                 rd_vld;
  logic [mem_pkg::NUM_RD-1:0][PADR_W-1:0]     rd_padr;

  word_t       model [NUMADDR];
  word_t       q_data [NPORT][$];
  padr_t       q_padr [NPORT][$];
  int          q_due [NPORT][$];
  int          ncyc;
  logic        ena_last;
  logic [31:0] seed;
  int          err_data;
  int          err_padr;
  int          err_vld;
  int          err_other;

  mem_4r1rw_top #(.WIDTH(WIDTH), .NUMADDR(NUMADDR)) uut (
    .clk(clk), .rst_n(rst_n), .ena_rdacc(ena_rdacc), .ready(ready),
    .rw_read(rw_read), .rw_write(rw_write), .rw_addr(rw_addr), .rw_din(rw_din),
    .rw_dout(rw_dout), .rw_vld(rw_vld), .rw_padr(rw_padr),
    .read(read), .rd_adr(rd_adr), .rd_dout(rd_dout), .rd_vld(rd_vld), .rd_padr(rd_padr)
  );

  always #5 clk = ~clk;

  function automatic logic [31:0] lcg_next();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  function automatic word_t rand_word();
    logic [31:0] r;
    r = lcg_next();
    return r[31:16];
  endfunction

  function automatic addr_t rand_addr();
    logic [31:0] r;
    r = lcg_next();
    return r[29:24];
  endfunction

  // {store, replica, row}.
  function automatic padr_t make_padr(input logic store, input int rep, input addr_t row);
    return {store, mem_pkg::REP_BITS'(rep), row};
  endfunction

  task automatic check_data(input string name, input word_t got, input word_t exp);
    if (got !== exp) begin
      $display("FAILED %s got %h expected %h", name, got, exp);
      err_data++;
    end
  endtask

  task automatic check_padr(input string name, input padr_t got, input padr_t exp);
    if (got !== exp) begin
      $display("FAILED %s got %h expected %h", name, got, exp);
      err_padr++;
    end
  endtask

  task automatic check_vld(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("FAILED %s got %h expected %h", name, got, exp);
      err_vld++;
    end
  endtask

  task automatic expect_result(input int port, input word_t d, input padr_t pa);
    q_data[port].push_back(d);
    q_padr[port].push_back(pa);
    q_due[port].push_back(ncyc + 2);  // Two cycles after the drive edge.
  endtask

  task automatic expect_reduced(input int port, input int rep, input addr_t a);
    word_t d;
    d = (int'(a) < HALF) ? model[a] : '0;
    expect_result(port, d, make_padr(1'b1, rep, addr_t'(int'(a) % HALF)));
  endtask

  // One cycle of stimulus, with the expected results queued per port.
  task automatic step(input logic ena, input logic wr, input addr_t wa, input word_t wd,
                      input logic rwr, input logic [3:0] rmask, input addr_vec_t ra);
    logic eff;
    @(posedge clk);
    eff = ena_last;  // Mode registered one edge before sampling.
    ena_last = ena;
    ena_rdacc <= ena;
    rw_write  <= wr;
    rw_addr   <= wa;
    rw_din    <= wd;
    rw_read   <= rwr;
    read      <= rmask;
    rd_adr    <= ra;
    for (int p = 0; p < mem_pkg::NUM_RD; p++) begin
      if (rmask[p]) begin
        if (!eff) expect_result(p, model[ra[p]], make_padr(1'b0, p, ra[p]));
        else if (p == 0) expect_reduced(0, 0, ra[p]);
      end
    end
    if (rwr && !wr) begin
      if (!eff) expect_result(4, model[wa], make_padr(1'b0, 4, wa));
      else expect_reduced(4, 1, wa);
    end
    if (wr) model[wa] = wd;
  endtask

  task automatic idle();
    step(ena_last, 1'b0, '0, '0, 1'b0, 4'b0000, '0);
  endtask

  function automatic int pending();
    int n;
    n = 0;
    for (int p = 0; p < NPORT; p++) n += q_due[p].size();
    return n;
  endfunction

  task automatic drain();
    int guard;
    guard = 0;
    while (pending() != 0 && guard < 10) begin
      idle();
      guard++;
    end
    if (pending() != 0) begin
      $display("Expected results never arrived on the outputs");
      err_other++;
    end
  endtask

  // Output monitor, stable at the falling edge.
  always @(negedge clk) begin
    if (rst_n) begin
      for (int p = 0; p < NPORT; p++) begin
        if (q_due[p].size() != 0 && q_due[p][0] == ncyc) begin
          if (p < mem_pkg::NUM_RD) begin
            check_vld($sformatf("rd_vld[%0d]", p), rd_vld[p], 1'b1);
            check_data($sformatf("rd_dout[%0d]", p), rd_dout[p], q_data[p][0]);
            check_padr($sformatf("rd_padr[%0d]", p), rd_padr[p], q_padr[p][0]);
          end else begin
            check_vld("rw_vld", rw_vld, 1'b1);
            check_data("rw_dout", rw_dout, q_data[p][0]);
            check_padr("rw_padr", rw_padr, q_padr[p][0]);
          end
          void'(q_data[p].pop_front());
          void'(q_padr[p].pop_front());
          void'(q_due[p].pop_front());
        end else if (p < mem_pkg::NUM_RD) begin
          check_vld($sformatf("rd_vld[%0d]", p), rd_vld[p], 1'b0);
        end else begin
          check_vld("rw_vld", rw_vld, 1'b0);
        end
      end
    end
    ncyc = ncyc + 1;
  end

  task automatic test_clear();
    int cnt;
    addr_vec_t ra;
    cnt = 0;
    do begin
      @(negedge clk);
      cnt++;
    end while (!ready && cnt < NUMADDR + 20);
    if (!ready) begin
      $display("ready never rose after reset");
      err_other++;
    end else if (cnt - 1 != NUMADDR + 1) begin
      $display("FAILED ready_cycles got %h expected %h", cnt - 1, NUMADDR + 1);
      err_other++;
    end
    for (int p = 0; p < mem_pkg::NUM_RD; p++) ra[p] = rand_addr();
    step(1'b0, 1'b0, rand_addr(), '0, 1'b1, 4'b1111, ra);
    drain();
  endtask

  task automatic test_full_mode();
    addr_t     list [8];
    addr_vec_t ra;
    for (int i = 0; i < 8; i++) begin
      list[i] = rand_addr();
      step(1'b0, 1'b1, list[i], rand_word(), 1'b0, 4'b0000, '0);
    end
    for (int i = 0; i < 8; i++) begin
      for (int p = 0; p < mem_pkg::NUM_RD; p++) ra[p] = list[i];
      step(1'b0, 1'b0, list[i], '0, 1'b1, 4'b1111, ra);
    end
    drain();
  endtask

  task automatic test_write_read_order();
    addr_t     a;
    addr_vec_t ra;
    a = rand_addr();
    ra = '0;
    ra[0] = a;
    step(1'b0, 1'b1, a, rand_word(), 1'b1, 4'b0001, ra);  // Old data, rw read dropped.
    step(1'b0, 1'b0, a, '0, 1'b0, 4'b0001, ra);           // New data.
    for (int i = 0; i < 6; i++) begin
      for (int p = 0; p < mem_pkg::NUM_RD; p++) ra[p] = rand_addr();
      step(1'b0, 1'b0, '0, '0, 1'b0, 4'b1110, ra);
    end
    drain();
  endtask

  task automatic test_reduced_mode();
    addr_t     list [4];
    addr_vec_t ra;
    step(1'b1, 1'b0, '0, '0, 1'b0, 4'b0000, '0);
    idle();
    for (int i = 0; i < 4; i++) begin
      list[i] = addr_t'(int'(rand_addr()) % HALF);
      step(1'b1, 1'b1, list[i], rand_word(), 1'b0, 4'b0000, '0);
    end
    for (int i = 0; i < 4; i++) begin
      for (int p = 0; p < mem_pkg::NUM_RD; p++) ra[p] = list[i];
      step(1'b1, 1'b0, list[(i + 1) % 4], '0, 1'b1, 4'b1111, ra);
    end
    ra = '0;
    ra[0] = addr_t'(HALF + 5);  // Upper half reads back zero.
    step(1'b1, 1'b0, addr_t'(NUMADDR - 1), '0, 1'b1, 4'b0001, ra);
    drain();
    step(1'b0, 1'b0, '0, '0, 1'b0, 4'b0000, '0);
    idle();
  endtask

  task automatic test_mode_switch();
    logic [31:0] r;
    addr_vec_t   ra;
    for (int i = 0; i < 12; i++) begin
      r = lcg_next();
      for (int p = 0; p < mem_pkg::NUM_RD; p++) ra[p] = rand_addr();
      step(r[20], 1'b0, rand_addr(), '0, 1'b1, 4'b1111, ra);
    end
    drain();
    step(1'b0, 1'b0, '0, '0, 1'b0, 4'b0000, '0);
    idle();
    drain();
  endtask

  // Watchdog.
  initial begin
    repeat (WDOG_CYC) @(posedge clk);
    $display("Timeout: tests did not finish within %0d cycles", WDOG_CYC);
    $display("FAIL: see errors above");
    $finish;
  end

  initial begin
    clk       = 1'b0;
    rst_n     = 1'b0;
    ena_rdacc = 1'b0;
    rw_read   = 1'b0;
    rw_write  = 1'b0;
    rw_addr   = '0;
    rw_din    = '0;
    read      = '0;
    rd_adr    = '0;
    ena_last  = 1'b0;
    seed      = 32'd4569;
    ncyc      = 0;
    err_data  = 0;
    err_padr  = 0;
    err_vld   = 0;
    err_other = 0;
    for (int i = 0; i < NUMADDR; i++) model[i] = '0;
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;
    test_clear();
    test_full_mode();
    test_write_read_order();
    test_reduced_mode();
    test_mode_switch();
    $display("Errors: data %0d, padr %0d, valid %0d, other %0d",
             err_data, err_padr, err_vld, err_other);
    if (err_data + err_padr + err_vld + err_other == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* tb/mem_4r1rw_asserts.sv */
// Memory port assertions
`default_nettype none

module mem_4r1rw_asserts (
  input logic                       clk,
  input logic                       rst_n,
  input logic                       ready,
  input logic                       mode_red,
  input logic [mem_pkg::NUM_RD-1:0] read,
  input logic                       rw_read,
  input logic                       rw_write,
  input logic [mem_pkg::NUM_RD-1:0] rd_vld,
  input logic                       rw_vld
);

  // Outputs stay quiet during reset.
  assert property (@(posedge clk) !rst_n |-> (rd_vld == '0 && !rw_vld))
    else $error("valid high during reset");

  assert property (@(posedge clk) disable iff (!rst_n) ready |=> ready)
    else $error("ready fell after rising");

  // Ports 1 to 3 are unserved in reduced mode.
  assert property (@(posedge clk) disable iff (!rst_n)
    (ready && mode_red && read[3:1] != 3'b000) |-> ##2 (rd_vld[3:1] == 3'b000))
    else $error("rd_vld[3:1] high for a reduced mode request");

  assert property (@(posedge clk) disable iff (!rst_n)
    rw_vld |-> $past(rw_read & ~rw_write & ready, 2))
    else $error("rw_vld without a request");

  for (genvar i = 0; i < mem_pkg::NUM_RD; i++) begin : g_rd
    assert property (@(posedge clk) disable iff (!rst_n)
      rd_vld[i] |-> $past(read[i] & ready, 2))
      else $error("rd_vld[%0d] without a request", i);
  end

endmodule

bind mem_4r1rw_top mem_4r1rw_asserts u_asserts (
  .clk(clk), .rst_n(rst_n), .ready(ready), .mode_red(mode_red),
  .read(read), .rw_read(rw_read), .rw_write(rw_write),
  .rd_vld(rd_vld), .rw_vld(rw_vld)
);

`default_nettype wire

/* rtl/mem_4r1rw_top.sv */
// Four read one read/write memory
`default_nettype none

module mem_4r1rw_top #(
  parameter int WIDTH    = mem_pkg::WIDTH,
  parameter int NUMADDR  = mem_pkg::NUMADDR,
  localparam int BITADDR = $clog2(NUMADDR),
  localparam int PADR_W  = 1 + mem_pkg::REP_BITS + BITADDR
) (
  input  logic                                      clk,
  input  logic                                      rst_n,
  input  logic                                      ena_rdacc,
  output logic                                      ready,
  // Read/write port.
  input  logic                                      rw_read,
  input  logic                                      rw_write,
  input  logic [BITADDR-1:0]                        rw_addr,
  input  logic [WIDTH-1:0]                          rw_din,
  output logic [WIDTH-1:0]                          rw_dout,
  output logic                                      rw_vld,
  output logic [PADR_W-1:0]                         rw_padr,
  // Read ports.
  input  logic [mem_pkg::NUM_RD-1:0]                read,
  input  logic [mem_pkg::NUM_RD-1:0][BITADDR-1:0]   rd_adr,
  output logic [mem_pkg::NUM_RD-1:0][WIDTH-1:0]     rd_dout,
  output logic [mem_pkg::NUM_RD-1:0]                rd_vld,
  output logic [mem_pkg::NUM_RD-1:0][PADR_W-1:0]    rd_padr
);

  localparam int NFP = mem_pkg::NUM_FULL_PORTS;
  localparam int NRP = mem_pkg::NUM_RED_PORTS;

  logic                           mode_red;
  logic                           wr_go;
  logic                           rw_rd_go;
  logic [mem_pkg::NUM_RD-1:0]     rd_go;

  logic [NFP-1:0]                 full_read;
  logic [NFP-1:0][BITADDR-1:0]    full_addr;
  logic [NFP-1:0]                 full_vld;
  logic [NFP-1:0][WIDTH-1:0]      full_dout;
  logic [NFP-1:0][PADR_W-1:0]     full_padr;
  logic                           full_done;

  logic [NRP-1:0]                 red_read;
  logic [NRP-1:0][BITADDR-1:0]    red_addr;
  logic [NRP-1:0]                 red_vld;
  logic [NRP-1:0][WIDTH-1:0]      red_dout;
  logic [NRP-1:0][PADR_W-1:0]     red_padr;
  logic                           red_done;

  // Requests accepted only once both stores are cleared.
  assign wr_go    = rw_write & ready;
  assign rw_rd_go = rw_read & ~rw_write & ready;  // Write wins over read.
  assign rd_go    = read & {mem_pkg::NUM_RD{ready}};

  assign full_read = {rw_rd_go, rd_go} & {NFP{~mode_red}};
  assign full_addr = {rw_addr, rd_adr};
  assign red_read  = {rw_rd_go, rd_go[0]} & {NRP{mode_red}};
  assign red_addr  = {rw_addr, rd_adr[0]};

  replica_store #(
    .WIDTH(WIDTH), .NUMADDR(NUMADDR), .DEPTH(NUMADDR), .NUM_PORTS(NFP), .STORE_ID(0)
  ) full_store (
    .clk(clk), .rst_n(rst_n),
    .write(wr_go), .wr_addr(rw_addr), .din(rw_din),
    .read(full_read), .rd_addr(full_addr),
    .rd_vld(full_vld), .rd_dout(full_dout), .rd_padr(full_padr),
    .done(full_done)
  );

  replica_store #(
    .WIDTH(WIDTH), .NUMADDR(NUMADDR), .DEPTH(NUMADDR / 2), .NUM_PORTS(NRP), .STORE_ID(1)
  ) red_store (
    .clk(clk), .rst_n(rst_n),
    .write(wr_go), .wr_addr(rw_addr), .din(rw_din),
    .read(red_read), .rd_addr(red_addr),
    .rd_vld(red_vld), .rd_dout(red_dout), .rd_padr(red_padr),
    .done(red_done)
  );

  port_select #(
    .WIDTH(WIDTH), .PADR_W(PADR_W)
  ) u_select (
    .clk(clk), .rst_n(rst_n), .ena_rdacc(ena_rdacc),
    .full_done(full_done), .red_done(red_done),
    .full_vld(full_vld), .full_dout(full_dout), .full_padr(full_padr),
    .red_vld(red_vld), .red_dout(red_dout), .red_padr(red_padr),
    .req_read(rd_go), .req_rw_read(rw_rd_go),
    .ready(ready), .mode_red(mode_red),
    .rd_vld(rd_vld), .rd_dout(rd_dout), .rd_padr(rd_padr),
    .rw_vld(rw_vld), .rw_dout(rw_dout), .rw_padr(rw_padr)
  );

endmodule

`default_nettype wire

/* rtl/port_select.sv */
// Store result selector
`default_nettype none

module port_select #(
  parameter int WIDTH  = mem_pkg::WIDTH,
  parameter int PADR_W = mem_pkg::PADR_W
) (
  input  logic                                            clk,
  input  logic                                            rst_n,
  input  logic                                            ena_rdacc,
  input  logic                                            full_done,
  input  logic                                            red_done,
  // Full store results.
  input  logic [mem_pkg::NUM_FULL_PORTS-1:0]              full_vld,
  input  logic [mem_pkg::NUM_FULL_PORTS-1:0][WIDTH-1:0]   full_dout,
  input  logic [mem_pkg::NUM_FULL_PORTS-1:0][PADR_W-1:0]  full_padr,
  // Reduced store results.
  input  logic [mem_pkg::NUM_RED_PORTS-1:0]               red_vld,
  input  logic [mem_pkg::NUM_RED_PORTS-1:0][WIDTH-1:0]    red_dout,
  input  logic [mem_pkg::NUM_RED_PORTS-1:0][PADR_W-1:0]   red_padr,
  // Accepted requests, already gated by ready.
  input  logic [mem_pkg::NUM_RD-1:0]                      req_read,
  input  logic                                            req_rw_read,
  output logic                                            ready,
  output logic                                            mode_red,
  output logic [mem_pkg::NUM_RD-1:0]                      rd_vld,
  output logic [mem_pkg::NUM_RD-1:0][WIDTH-1:0]           rd_dout,
  output logic [mem_pkg::NUM_RD-1:0][PADR_W-1:0]          rd_padr,
  output logic                                            rw_vld,
  output logic [WIDTH-1:0]                                rw_dout,
  output logic [PADR_W-1:0]                               rw_padr
);

  localparam int NUM_RD  = mem_pkg::NUM_RD;
  localparam int RW_PORT = mem_pkg::NUM_RD;  // rw port index in the full store.
  localparam int RED_RW  = 1;                // rw port index in the reduced store.

  logic                                   mode_iss;  // Mode of the requests now in the stores.
  logic [mem_pkg::NUM_FULL_PORTS-1:0]     req_q;

  assign ready = full_done & red_done;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mode_red <= 1'b0;
      mode_iss <= 1'b0;
      req_q    <= '0;
      rd_vld   <= '0;
      rw_vld   <= 1'b0;
    end else begin
      mode_red <= ena_rdacc;
      mode_iss <= mode_red;
      req_q    <= {req_rw_read, req_read};
      rd_vld[0] <= req_q[0] & (mode_iss ? red_vld[0] : full_vld[0]);
      for (int i = 1; i < NUM_RD; i++) begin
        rd_vld[i] <= req_q[i] & ~mode_iss & full_vld[i];  // Unserved in reduced mode.
      end
      rw_vld <= req_q[RW_PORT] & (mode_iss ? red_vld[RED_RW] : full_vld[RW_PORT]);
    end
  end

  // Payload follows the mode each request was issued under.
  always_ff @(posedge clk) begin
    rd_dout[0] <= mode_iss ? red_dout[0] : full_dout[0];
    rd_padr[0] <= mode_iss ? red_padr[0] : full_padr[0];
    for (int i = 1; i < NUM_RD; i++) begin
      rd_dout[i] <= full_dout[i];
      rd_padr[i] <= full_padr[i];
    end
    rw_dout <= mode_iss ? red_dout[RED_RW] : full_dout[RW_PORT];
    rw_padr <= mode_iss ? red_padr[RED_RW] : full_padr[RW_PORT];
  end

endmodule

`default_nettype wire

/* rtl/replica_store.sv */
// Replicated single-write memory store
`default_nettype none

module replica_store #(
  parameter int WIDTH     = mem_pkg::WIDTH,
  parameter int NUMADDR   = mem_pkg::NUMADDR,
  parameter int DEPTH     = mem_pkg::NUMADDR,
  parameter int NUM_PORTS = mem_pkg::NUM_FULL_PORTS,
  parameter int STORE_ID  = 0,
  localparam int ADDR_W   = $clog2(NUMADDR),
  localparam int PADR_W   = 1 + mem_pkg::REP_BITS + ADDR_W
) (
  input  logic                                clk,
  input  logic                                rst_n,
  // Write port, shared by all replicas.
  input  logic                                write,
  input  logic [ADDR_W-1:0]                   wr_addr,
  input  logic [WIDTH-1:0]                    din,
  // One read port per replica.
  input  logic [NUM_PORTS-1:0]                read,
  input  logic [NUM_PORTS-1:0][ADDR_W-1:0]    rd_addr,
  output logic [NUM_PORTS-1:0]                rd_vld,
  output logic [NUM_PORTS-1:0][WIDTH-1:0]     rd_dout,
  output logic [NUM_PORTS-1:0][PADR_W-1:0]    rd_padr,
  output logic                                done
);

  localparam int ROW_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  // One copy of the array per read port.
  logic [WIDTH-1:0] mem [NUM_PORTS][DEPTH];

  logic [CNT_W-1:0] clr_cnt;
  logic             mem_we;
  logic [ROW_W-1:0] mem_row;
  logic [WIDTH-1:0] mem_din;

  function automatic logic in_range(input logic [ADDR_W-1:0] a);
    return int'(a) < DEPTH;
  endfunction

  // Row inside this store, wraps for addresses past DEPTH.
  function automatic logic [ROW_W-1:0] row_of(input logic [ADDR_W-1:0] a);
    return ROW_W'(int'(a) % DEPTH);
  endfunction

  // Clear sweep, one row per cycle after reset.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      clr_cnt <= '0;
      done    <= 1'b0;
    end else if (!done) begin
      if (int'(clr_cnt) == DEPTH) begin
        done <= 1'b1;
      end else begin
        clr_cnt <= clr_cnt + 1'b1;
      end
    end
  end

  // Sweep owns the write port until done.
  always_comb begin
    if (!done) begin
      mem_we  = int'(clr_cnt) < DEPTH;
      mem_row = ROW_W'(clr_cnt);
      mem_din = '0;
    end else begin
      mem_we  = write & in_range(wr_addr);  // Out of range writes dropped.
      mem_row = row_of(wr_addr);
      mem_din = din;
    end
  end

  always_ff @(posedge clk) begin
    if (mem_we) begin
      for (int p = 0; p < NUM_PORTS; p++) begin
        mem[p][mem_row] <= mem_din;
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_vld <= '0;
    end else begin
      rd_vld <= read;
    end
  end

  // Reads see the array before a write on the same edge.
  always_ff @(posedge clk) begin
    for (int p = 0; p < NUM_PORTS; p++) begin
      if (read[p]) begin
        rd_dout[p] <= in_range(rd_addr[p]) ? mem[p][row_of(rd_addr[p])] : '0;
        rd_padr[p] <= {STORE_ID[0], mem_pkg::REP_BITS'(p), ADDR_W'(row_of(rd_addr[p]))};
      end
    end
  end

endmodule

`default_nettype wire

/* rtl/mem_pkg.sv */
// Multiport memory shared definitions
`default_nettype none

package mem_pkg;

  // Default geometry, overridden through module parameters.
  localparam int WIDTH   = 32;
  localparam int NUMADDR = 1024;
  localparam int BITADDR = $clog2(NUMADDR);

  // Port counts.
  localparam int NUM_RD         = 4;
  localparam int NUM_FULL_PORTS = NUM_RD + 1;  // Read ports plus the rw port.
  localparam int NUM_RED_PORTS  = 2;           // read[0] and the rw port.

  // Physical address is {store, replica, row}.
  localparam int REP_BITS = 3;
  localparam int PADR_W   = 1 + REP_BITS + BITADDR;

  typedef logic [WIDTH-1:0]   word_t;
  typedef logic [BITADDR-1:0] addr_t;
  typedef logic [PADR_W-1:0]  padr_t;

endpackage

`default_nettype wire
